/* build.f */
rtl/mac_attach_pkg.sv
rtl/axis_if.sv
rtl/stat_if.sv
rtl/rx_frame_queue.sv
rtl/tx_frame_queue.sv
rtl/stat_counters.sv
rtl/reg_access.sv
rtl/mac_attach_top.sv
verif/mac_attach_tb.sv

/* verif/mac_attach_tb.sv */
/*
  Directed testbench for the MAC attachment top level.
  Covers registers, receive tagging and drops, transmit store-and-forward and counters.
*/
`timescale 1ns/1ps

module mac_attach_tb;
  import mac_attach_pkg::*;

  localparam int WAIT_LIMIT = 4000;
  localparam int RX_BEAT_W  = 1 + KEEP_W + DATA_W + TUSER_W;
  localparam int TX_BEAT_W  = 1 + KEEP_W + DATA_W;

  logic axis_aclk = 1'b0;
  logic i_reset;
  logic [PORT_W-1:0] i_port_num;
  logic [TS_W-1:0] i_stamp_counter;
  logic [DATA_W-1:0] i_mac_rx_tdata, o_pipe_rx_tdata, i_pipe_tx_tdata, o_mac_tx_tdata;
  logic [KEEP_W-1:0] i_mac_rx_tkeep, o_pipe_rx_tkeep, i_pipe_tx_tkeep, o_mac_tx_tkeep;
  logic i_mac_rx_tvalid, i_mac_rx_tlast, i_mac_rx_tuser_err;
  logic o_pipe_rx_tlast, o_pipe_rx_tvalid, i_pipe_rx_tready;
  logic [TUSER_W-1:0] o_pipe_rx_tuser, i_pipe_tx_tuser;
  logic i_pipe_tx_tlast, i_pipe_tx_tvalid, o_pipe_tx_tready;
  logic o_mac_tx_tlast, o_mac_tx_tvalid, i_mac_tx_tready;
  logic i_reg_req, i_reg_wr, o_reg_ack;
  logic [REG_ADDR_W-1:0] i_reg_addr;
  logic [REG_W-1:0] i_reg_wdata, o_reg_rdata;

  // Expected beats and tallies for the counter test
  logic [RX_BEAT_W-1:0] rx_exp [$];
  logic [TX_BEAT_W-1:0] tx_exp [$];
  int rx_mac_frames, rx_drops, rx_pipe_frames, tx_in_frames, tx_out_frames;
  logic rx_ready_rand, rx_ready_hold, tx_ready_rand;
  logic tx_mid, tx_hold;

  mac_attach_top mac_attach_top_i (.*);

  always #2 axis_aclk = ~axis_aclk;

  // Free-running stamp and ready patterns driven on the falling edge
  always @(negedge axis_aclk) begin
    i_stamp_counter  <= i_stamp_counter + 1'b1;
    i_pipe_rx_tready <= rx_ready_rand ? 1'($urandom_range(0, 1)) : rx_ready_hold;
    i_mac_tx_tready  <= tx_ready_rand ? 1'($urandom_range(0, 1)) : 1'b1;
  end

  task automatic abort_run();
    $display("Test failed");
    $fatal(1);
  endtask

  // ----------------------------------------
  // Stream monitors
  // ----------------------------------------
  always @(posedge axis_aclk) begin
    logic [RX_BEAT_W-1:0] want;
    if (!i_reset && o_pipe_rx_tvalid && i_pipe_rx_tready) begin
      assert (rx_exp.size() != 0) else begin
        $display("Pipeline receive output sent a beat that was not expected");
        abort_run();
      end
      want = rx_exp.pop_front();
      assert ({o_pipe_rx_tlast, o_pipe_rx_tkeep, o_pipe_rx_tdata} ==
              want[RX_BEAT_W-1:TUSER_W]) else begin
        $display("MISMATCH o_pipe_rx tlast/tkeep/tdata exp %h got %h",
                 want[RX_BEAT_W-1:TUSER_W], {o_pipe_rx_tlast, o_pipe_rx_tkeep, o_pipe_rx_tdata});
        abort_run();
      end
      assert (o_pipe_rx_tuser == want[TUSER_W-1:0]) else begin
        $display("MISMATCH o_pipe_rx_tuser exp %h got %h", want[TUSER_W-1:0], o_pipe_rx_tuser);
        abort_run();
      end
      if (want[RX_BEAT_W-1]) begin
        rx_pipe_frames++;
      end
    end
  end

  always @(posedge axis_aclk) begin
    logic [TX_BEAT_W-1:0] want;
    if (!i_reset) begin
      assert (o_mac_tx_tvalid || !(tx_mid || tx_hold)) else begin
        $display("MAC transmit tvalid fell inside a frame or before tready");
        abort_run();
      end
      assert (!o_mac_tx_tvalid || tx_mid || tx_in_frames > tx_out_frames) else begin
        $display("MAC transmit tvalid rose before the whole frame was stored");
        abort_run();
      end
      tx_hold <= o_mac_tx_tvalid && !i_mac_tx_tready;
      if (o_mac_tx_tvalid && i_mac_tx_tready) begin
        assert (tx_exp.size() != 0) else begin
          $display("MAC transmit output sent a beat that was not expected");
          abort_run();
        end
        want = tx_exp.pop_front();
        assert ({o_mac_tx_tlast, o_mac_tx_tkeep, o_mac_tx_tdata} == want) else begin
          $display("MISMATCH o_mac_tx tlast/tkeep/tdata exp %h got %h",
                   want, {o_mac_tx_tlast, o_mac_tx_tkeep, o_mac_tx_tdata});
          abort_run();
        end
        tx_mid <= !want[TX_BEAT_W-1];
        if (want[TX_BEAT_W-1]) begin
          tx_out_frames <= tx_out_frames + 1;
        end
      end
      if (i_pipe_tx_tvalid && o_pipe_tx_tready) begin
        tx_exp.push_back({i_pipe_tx_tlast, i_pipe_tx_tkeep, i_pipe_tx_tdata});
        if (i_pipe_tx_tlast) begin
          tx_in_frames <= tx_in_frames + 1;
        end
      end
    end
  end

  // ----------------------------------------
  // Drivers
  // ----------------------------------------
  task automatic send_mac_frame(input int beats, input bit err, input bit kept);
    logic [RX_BEAT_W-TUSER_W-1:0] beat [17];
    logic [TUSER_W-1:0] tag;
    tag = '0;
    for (int i = 0; i < beats; i++) begin
      @(negedge axis_aclk);
      i_mac_rx_tvalid    = 1'b1;
      i_mac_rx_tlast     = (i == beats - 1);
      i_mac_rx_tuser_err = err && (i == beats - 1);
      i_mac_rx_tdata     = {$urandom, $urandom};
      i_mac_rx_tkeep     = (i == beats - 1) ? 8'($urandom_range(1, 255)) : 8'hFF;
      beat[i] = {i_mac_rx_tlast, i_mac_rx_tkeep, i_mac_rx_tdata};
      if (i == 0) begin
        @(posedge axis_aclk);
        tag[SRC_PORT_HI:SRC_PORT_LO] = i_port_num;
        tag[TS_HI:TS_LO]             = i_stamp_counter;
      end
    end
    @(negedge axis_aclk);
    i_mac_rx_tvalid = 1'b0;
    i_mac_rx_tlast  = 1'b0;
    i_mac_rx_tuser_err = 1'b0;
    rx_mac_frames++;
    if (kept) begin
      for (int i = 0; i < beats; i++) begin
        rx_exp.push_back({beat[i], tag});
      end
    end else begin
      rx_drops++;
    end
  endtask

  task automatic send_pipe_frame(input int beats);
    int n;
    for (int i = 0; i < beats; i++) begin
      @(negedge axis_aclk);
      i_pipe_tx_tvalid = 1'b1;
      i_pipe_tx_tlast  = (i == beats - 1);
      i_pipe_tx_tdata  = {$urandom, $urandom};
      i_pipe_tx_tkeep  = (i == beats - 1) ? 8'($urandom_range(1, 255)) : 8'hFF;
      i_pipe_tx_tuser  = {$urandom, $urandom, $urandom, $urandom};
      for (n = 0; n < WAIT_LIMIT; n++) begin
        @(posedge axis_aclk);
        if (o_pipe_tx_tready) break;
      end
      if (n == WAIT_LIMIT) begin
        $display("Timeout waiting for pipeline transmit tready");
        abort_run();
      end
    end
    @(negedge axis_aclk);
    i_pipe_tx_tvalid = 1'b0;
    i_pipe_tx_tlast  = 1'b0;
  endtask

  task automatic reg_access_cycle(input bit wr, input logic [REG_ADDR_W-1:0] addr,
                                  input logic [REG_W-1:0] wdata, output logic [REG_W-1:0] rdata);
    int n;
    @(negedge axis_aclk);
    i_reg_req   = 1'b1;
    i_reg_wr    = wr;
    i_reg_addr  = addr;
    i_reg_wdata = wdata;
    for (n = 0; n < WAIT_LIMIT; n++) begin
      @(posedge axis_aclk);
      if (o_reg_ack) break;
    end
    if (n == WAIT_LIMIT) begin
      $display("Timeout waiting for register ack to rise");
      abort_run();
    end
    rdata = o_reg_rdata;
    @(negedge axis_aclk);
    i_reg_req = 1'b0;
    for (n = 0; n < WAIT_LIMIT; n++) begin
      @(posedge axis_aclk);
      if (!o_reg_ack) break;
    end
    if (n == WAIT_LIMIT) begin
      $display("Timeout waiting for register ack to fall");
      abort_run();
    end
  endtask

  task automatic check_reg(input logic [REG_ADDR_W-1:0] addr, input logic [REG_W-1:0] want);
    logic [REG_W-1:0] got;
    reg_access_cycle(1'b0, addr, '0, got);
    assert (got == want) else begin
      $display("MISMATCH o_reg_rdata at addr %h exp %h got %h", addr, want, got);
      abort_run();
    end
  endtask

  task automatic wait_streams_drained();
    int n;
    for (n = 0; n < WAIT_LIMIT; n++) begin
      @(posedge axis_aclk);
      if (rx_exp.size() == 0 && tx_exp.size() == 0 && !o_mac_tx_tvalid) break;
    end
    if (n == WAIT_LIMIT) begin
      $display("Timeout waiting for the expected frames to come out");
      abort_run();
    end
  endtask

  // ----------------------------------------
  // Directed tests
  // ----------------------------------------
  task automatic test_registers();
    logic [REG_W-1:0] v;
    logic [REG_W-1:0] unused;
    v = $urandom;
    check_reg(ID, ID_VALUE);
    check_reg(VERSION, VERSION_VALUE);
    reg_access_cycle(1'b1, FLIP, v, unused);
    reg_access_cycle(1'b1, DEBUG, v, unused);
    check_reg(FLIP, ~v);
    check_reg(DEBUG, DEBUG_DEFAULT + v);
    check_reg(RESET, '0);
  endtask

  task automatic test_rx_delivery();
    rx_ready_rand = 1'b1;
    for (int k = 0; k < 6; k++) begin
      send_mac_frame($urandom_range(1, 16), 1'b0, 1'b1);
      wait_streams_drained();
    end
  endtask

  task automatic test_rx_drops();
    rx_ready_rand = 1'b0;
    rx_ready_hold = 1'b0;
    send_mac_frame(6, 1'b1, 1'b0);
    send_mac_frame(17, 1'b0, 1'b0);
    // Room for four maximum frames and none for the fifth
    for (int k = 0; k < 4; k++) begin
      send_mac_frame(16, 1'b0, 1'b1);
    end
    send_mac_frame(16, 1'b0, 1'b0);
    rx_ready_rand = 1'b1;
    wait_streams_drained();
    // With tready low again any leftover beat stays on tvalid
    rx_ready_rand = 1'b0;
    repeat (8) @(posedge axis_aclk);
    assert (!o_pipe_rx_tvalid) else begin
      $display("Receive queue still holds data after the kept frames");
      abort_run();
    end
  endtask

  task automatic test_tx_store_forward();
    tx_ready_rand = 1'b1;
    for (int k = 0; k < 8; k++) begin
      send_pipe_frame($urandom_range(1, 16));
    end
    wait_streams_drained();
  endtask

  task automatic test_counters();
    logic [REG_W-1:0] unused;
    check_reg(RX_MAC_PKTS, rx_mac_frames);
    check_reg(RX_DROP_PKTS, rx_drops);
    check_reg(RX_PIPE_PKTS, rx_pipe_frames);
    check_reg(TX_PIPE_PKTS, tx_in_frames);
    check_reg(TX_MAC_PKTS, tx_out_frames);
    reg_access_cycle(1'b1, RESET, 32'h1, unused);
    check_reg(RX_MAC_PKTS, '0);
    check_reg(RX_DROP_PKTS, '0);
    check_reg(RX_PIPE_PKTS, '0);
    check_reg(TX_PIPE_PKTS, '0);
    check_reg(TX_MAC_PKTS, '0);
  endtask

  initial begin
    void'($urandom(32'ha732_926e));
    i_reset = 1'b1;
    i_port_num = 8'($urandom);
    i_stamp_counter = {$urandom, $urandom};
    {i_mac_rx_tdata, i_mac_rx_tkeep, i_mac_rx_tvalid, i_mac_rx_tlast, i_mac_rx_tuser_err} = '0;
    {i_pipe_tx_tdata, i_pipe_tx_tkeep, i_pipe_tx_tlast, i_pipe_tx_tuser, i_pipe_tx_tvalid} = '0;
    {i_reg_req, i_reg_wr, i_reg_addr, i_reg_wdata} = '0;
    {i_pipe_rx_tready, i_mac_tx_tready} = 2'b11;
    rx_ready_rand = 1'b0;
    tx_ready_rand = 1'b0;
    rx_ready_hold = 1'b1;
    {tx_mid, tx_hold} = 2'b00;
    repeat (16) @(posedge axis_aclk);
    @(negedge axis_aclk);
    i_reset = 1'b0;
    @(posedge axis_aclk);
    assert (o_pipe_tx_tready && !o_mac_tx_tvalid && !o_pipe_rx_tvalid && !o_reg_ack) else begin
      $display("Outputs are not in their reset state after reset");
      abort_run();
    end
    test_registers();
    test_rx_delivery();
    test_rx_drops();
    test_tx_store_forward();
    test_counters();
    $display("Test passed");
    $finish;
  end

endmodule

/* rtl/mac_attach_top.sv */
/*
  MAC attachment top level with plain stream and register ports.
  Receive queue, statistics, register block and transmit queue on one clock.
*/
`timescale 1ns/1ps

module mac_attach_top (
  input  logic                                  axis_aclk,
  input  logic                                  i_reset,
  input  logic [mac_attach_pkg::PORT_W-1:0]     i_port_num,
  input  logic [mac_attach_pkg::TS_W-1:0]       i_stamp_counter,
  // MAC receive, no back-pressure
  input  logic [mac_attach_pkg::DATA_W-1:0]     i_mac_rx_tdata,
  input  logic [mac_attach_pkg::KEEP_W-1:0]     i_mac_rx_tkeep,
  input  logic                                  i_mac_rx_tvalid,
  input  logic                                  i_mac_rx_tlast,
  input  logic                                  i_mac_rx_tuser_err,
  // Pipeline receive
  output logic [mac_attach_pkg::DATA_W-1:0]     o_pipe_rx_tdata,
  output logic [mac_attach_pkg::KEEP_W-1:0]     o_pipe_rx_tkeep,
  output logic                                  o_pipe_rx_tlast,
  output logic [mac_attach_pkg::TUSER_W-1:0]    o_pipe_rx_tuser,
  output logic                                  o_pipe_rx_tvalid,
  input  logic                                  i_pipe_rx_tready,
  // Pipeline transmit
  input  logic [mac_attach_pkg::DATA_W-1:0]     i_pipe_tx_tdata,
  input  logic [mac_attach_pkg::KEEP_W-1:0]     i_pipe_tx_tkeep,
  input  logic                                  i_pipe_tx_tlast,
  input  logic [mac_attach_pkg::TUSER_W-1:0]    i_pipe_tx_tuser,
  input  logic                                  i_pipe_tx_tvalid,
  output logic                                  o_pipe_tx_tready,
  // MAC transmit
  output logic [mac_attach_pkg::DATA_W-1:0]     o_mac_tx_tdata,
  output logic [mac_attach_pkg::KEEP_W-1:0]     o_mac_tx_tkeep,
  output logic                                  o_mac_tx_tlast,
  output logic                                  o_mac_tx_tvalid,
  input  logic                                  i_mac_tx_tready,
  // Register port
  input  logic                                  i_reg_req,
  input  logic                                  i_reg_wr,
  input  logic [mac_attach_pkg::REG_ADDR_W-1:0] i_reg_addr,
  input  logic [mac_attach_pkg::REG_W-1:0]      i_reg_wdata,
  output logic                                  o_reg_ack,
  output logic [mac_attach_pkg::REG_W-1:0]      o_reg_rdata
);

  axis_if rx_pipe ();
  stat_if stat_bus ();

  assign o_pipe_rx_tdata  = rx_pipe.tdata;
  assign o_pipe_rx_tkeep  = rx_pipe.tkeep;
  assign o_pipe_rx_tlast  = rx_pipe.tlast;
  assign o_pipe_rx_tuser  = rx_pipe.tuser;
  assign o_pipe_rx_tvalid = rx_pipe.tvalid;
  assign rx_pipe.tready   = i_pipe_rx_tready;

  // ----------------------------------------
  // Input side
  // ----------------------------------------
  rx_frame_queue rx_frame_queue_i (
    .axis_aclk       (axis_aclk),
    .i_reset         (i_reset),
    .i_mac_tdata     (i_mac_rx_tdata),
    .i_mac_tkeep     (i_mac_rx_tkeep),
    .i_mac_tvalid    (i_mac_rx_tvalid),
    .i_mac_tlast     (i_mac_rx_tlast),
    .i_mac_tuser_err (i_mac_rx_tuser_err),
    .i_port_num      (i_port_num),
    .i_stamp_counter (i_stamp_counter),
    .o_pipe          (rx_pipe),
    .stat            (stat_bus)
  );

  // ----------------------------------------
  // Processing
  // ----------------------------------------
  stat_counters stat_counters_i (
    .axis_aclk (axis_aclk),
    .i_reset   (i_reset),
    .stat      (stat_bus)
  );

  reg_access reg_access_i (
    .axis_aclk   (axis_aclk),
    .i_reset     (i_reset),
    .i_reg_req   (i_reg_req),
    .i_reg_wr    (i_reg_wr),
    .i_reg_addr  (i_reg_addr),
    .i_reg_wdata (i_reg_wdata),
    .o_reg_ack   (o_reg_ack),
    .o_reg_rdata (o_reg_rdata),
    .stat        (stat_bus)
  );

  // ----------------------------------------
  // Output side
  // ----------------------------------------
  tx_frame_queue tx_frame_queue_i (
    .axis_aclk     (axis_aclk),
    .i_reset       (i_reset),
    .i_pipe_tdata  (i_pipe_tx_tdata),
    .i_pipe_tkeep  (i_pipe_tx_tkeep),
    .i_pipe_tlast  (i_pipe_tx_tlast),
    .i_pipe_tuser  (i_pipe_tx_tuser),
    .i_pipe_tvalid (i_pipe_tx_tvalid),
    .o_pipe_tready (o_pipe_tx_tready),
    .o_mac_tdata   (o_mac_tx_tdata),
    .o_mac_tkeep   (o_mac_tx_tkeep),
    .o_mac_tlast   (o_mac_tx_tlast),
    .o_mac_tvalid  (o_mac_tx_tvalid),
    .i_mac_tready  (i_mac_tx_tready),
    .stat          (stat_bus)
  );

endmodule

/* rtl/reg_access.sv */
/*
  Four-phase req/ack register responder with the identity, test and counter registers.
  Each request is served once, on the edge that first samples req high.
*/
`timescale 1ns/1ps

module reg_access (
  input  logic                                  axis_aclk,
  input  logic                                  i_reset,
  input  logic                                  i_reg_req,
  input  logic                                  i_reg_wr,
  input  logic [mac_attach_pkg::REG_ADDR_W-1:0] i_reg_addr,
  input  logic [mac_attach_pkg::REG_W-1:0]      i_reg_wdata,
  output logic                                  o_reg_ack,
  output logic [mac_attach_pkg::REG_W-1:0]      o_reg_rdata,
  stat_if.regs                                  stat
);
  import mac_attach_pkg::*;

  reg_state_e       state;
  logic [REG_W-1:0] flip_q;
  logic [REG_W-1:0] debug_q;
  logic [REG_W-1:0] rd_val;
  logic             access;
  logic             clear_q;

  // A request seen while ack is low starts a new access
  assign access     = i_reg_req && (state != ACK);
  assign o_reg_ack  = (state == ACK);
  assign stat.clear = clear_q;

  // ----------------------------------------
  // Read mux
  // ----------------------------------------
  always_comb begin
    case (reg_addr_e'(i_reg_addr))
      ID:           rd_val = ID_VALUE;
      VERSION:      rd_val = VERSION_VALUE;
      FLIP:         rd_val = ~flip_q;
      DEBUG:        rd_val = DEBUG_DEFAULT + debug_q;
      RX_MAC_PKTS:  rd_val = stat.rx_mac_pkts;
      RX_DROP_PKTS: rd_val = stat.rx_drop_pkts;
      RX_PIPE_PKTS: rd_val = stat.rx_pipe_pkts;
      TX_PIPE_PKTS: rd_val = stat.tx_pipe_pkts;
      TX_MAC_PKTS:  rd_val = stat.tx_mac_pkts;
      default:      rd_val = '0;
    endcase
  end

  // ----------------------------------------
  // Handshake FSM and write side
  // ----------------------------------------
  always_ff @(posedge axis_aclk) begin
    if (i_reset) begin
      state   <= IDLE;
      flip_q  <= '0;
      debug_q <= '0;
      clear_q <= 1'b0;
    end else begin
      clear_q <= access && i_reg_wr && (i_reg_addr == RESET) && i_reg_wdata[0];
      case (state)
        ACK: begin
          if (!i_reg_req) begin
            state <= RELEASE;
          end
        end
        default: begin
          state <= i_reg_req ? ACK : IDLE;
        end
      endcase
      if (access && i_reg_wr) begin
        case (reg_addr_e'(i_reg_addr))
          FLIP:    flip_q  <= i_reg_wdata;
          DEBUG:   debug_q <= i_reg_wdata;
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge axis_aclk) begin
    if (access && !i_reg_wr) begin
      o_reg_rdata <= rd_val;
    end
  end

endmodule

/* rtl/stat_counters.sv */
/*
  Five packet counters with a sticky overflow flag in the top bit
*/
`timescale 1ns/1ps

module stat_counters (
  input  logic axis_aclk,
  input  logic i_reset,
  stat_if.cnt  stat
);
  import mac_attach_pkg::*;

  logic [4:0]       evt;
  logic [CNT_W-1:0] cnt [5];

  // Order matches the register map
  assign evt = {stat.tx_mac_eop, stat.tx_pipe_eop, stat.rx_pipe_eop,
                stat.rx_drop, stat.rx_mac_eop};

  always_ff @(posedge axis_aclk) begin
    logic [CNT_W-1:0] sum;
    for (int i = 0; i < 5; i++) begin
      // Carry out of the low bits lands in sum's top bit
      sum = {1'b0, cnt[i][CNT_W-2:0]} + 1'b1;
      if (i_reset || stat.clear) begin
        cnt[i] <= '0;
      end else if (evt[i]) begin
        cnt[i] <= {cnt[i][CNT_W-1] | sum[CNT_W-1], sum[CNT_W-2:0]};
      end
    end
  end

  assign stat.rx_mac_pkts  = cnt[0];
  assign stat.rx_drop_pkts = cnt[1];
  assign stat.rx_pipe_pkts = cnt[2];
  assign stat.tx_pipe_pkts = cnt[3];
  assign stat.tx_mac_pkts  = cnt[4];

endmodule

/* rtl/tx_frame_queue.sv */
/*
  Transmit store-and-forward queue from the pipeline to the MAC.
  A frame is offered to the MAC only after its last beat is stored.
*/
`timescale 1ns/1ps

module tx_frame_queue (
  input  logic                               axis_aclk,
  input  logic                               i_reset,
  input  logic [mac_attach_pkg::DATA_W-1:0]  i_pipe_tdata,
  input  logic [mac_attach_pkg::KEEP_W-1:0]  i_pipe_tkeep,
  input  logic                               i_pipe_tlast,
  input  logic [mac_attach_pkg::TUSER_W-1:0] i_pipe_tuser,
  input  logic                               i_pipe_tvalid,
  output logic                               o_pipe_tready,
  output logic [mac_attach_pkg::DATA_W-1:0]  o_mac_tdata,
  output logic [mac_attach_pkg::KEEP_W-1:0]  o_mac_tkeep,
  output logic                               o_mac_tlast,
  output logic                               o_mac_tvalid,
  input  logic                               i_mac_tready,
  stat_if.tx_q                               stat
);
  import mac_attach_pkg::*;

  // Sideband from the pipeline has no meaning at the MAC and is not stored
  logic [KEEP_W+DATA_W:0] mem [FIFO_DEPTH];

  logic [PTR_W:0] wr_ptr;
  logic [PTR_W:0] rd_ptr;
  logic [PTR_W:0] used;
  logic [PTR_W:0] frame_cnt;
  logic           wr_en;
  logic           rd_en;
  logic           in_eop;
  logic           out_eop;

  assign used          = wr_ptr - rd_ptr;
  assign o_pipe_tready = (used != FIFO_DEPTH);
  assign wr_en         = i_pipe_tvalid && o_pipe_tready;
  assign in_eop        = wr_en && i_pipe_tlast;

  // Complete frames stored keep tvalid up for a whole frame
  assign o_mac_tvalid  = (frame_cnt != '0);
  assign {o_mac_tlast, o_mac_tkeep, o_mac_tdata} = mem[rd_ptr[PTR_W-1:0]];
  assign rd_en         = o_mac_tvalid && i_mac_tready;
  assign out_eop       = rd_en && o_mac_tlast;

  always_ff @(posedge axis_aclk) begin
    if (i_reset) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      frame_cnt <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (in_eop && !out_eop) begin
        frame_cnt <= frame_cnt + 1'b1;
      end else if (out_eop && !in_eop) begin
        frame_cnt <= frame_cnt - 1'b1;
      end
    end
  end

  always_ff @(posedge axis_aclk) begin
    if (wr_en) begin
      mem[wr_ptr[PTR_W-1:0]] <= {i_pipe_tlast, i_pipe_tkeep, i_pipe_tdata};
    end
  end

  assign stat.tx_pipe_eop = in_eop;
  assign stat.tx_mac_eop  = out_eop;

endmodule

/* rtl/rx_frame_queue.sv */
/*
  Receive store-and-forward queue between the MAC and the pipeline.
  Admits a frame only with room for a maximum frame and rolls back bad or long ones.
*/
`timescale 1ns/1ps

module rx_frame_queue (
  input  logic                              axis_aclk,
  input  logic                              i_reset,
  input  logic [mac_attach_pkg::DATA_W-1:0] i_mac_tdata,
  input  logic [mac_attach_pkg::KEEP_W-1:0] i_mac_tkeep,
  input  logic                              i_mac_tvalid,
  input  logic                              i_mac_tlast,
  input  logic                              i_mac_tuser_err,
  input  logic [mac_attach_pkg::PORT_W-1:0] i_port_num,
  input  logic [mac_attach_pkg::TS_W-1:0]   i_stamp_counter,
  axis_if.src                               o_pipe,
  stat_if.rx_q                              stat
);
  import mac_attach_pkg::*;

  logic [KEEP_W+DATA_W+TUSER_W:0] mem [FIFO_DEPTH];

  logic [PTR_W:0]     wr_ptr;
  logic [PTR_W:0]     commit_ptr;
  logic [PTR_W:0]     rd_ptr;
  logic [PTR_W:0]     used;
  logic [PTR_W:0]     free;
  logic [PTR_W-1:0]   beat_cnt;
  logic               in_frame;
  logic               discard;
  logic [TS_W-1:0]    ts_q;
  logic [TS_W-1:0]    ts_cur;
  logic [TUSER_W-1:0] tuser;
  logic               first;
  logic               keep_frame;
  logic               too_long;
  logic               wr_beat;
  logic               rollback;
  logic               end_ok;
  logic               rd_en;

  // ----------------------------------------
  // Frame admission
  // ----------------------------------------
  assign used       = wr_ptr - rd_ptr;
  assign free       = (PTR_W+1)'(FIFO_DEPTH) - used;
  assign first      = !in_frame;
  // Free space is judged once per frame, at its first beat
  assign keep_frame = first ? (free >= MAX_FRAME_BEATS) : !discard;
  assign too_long   = !first && (beat_cnt == MAX_FRAME_BEATS);
  assign wr_beat    = i_mac_tvalid && keep_frame && !too_long;
  assign rollback   = i_mac_tvalid && keep_frame &&
                      (too_long || (i_mac_tlast && i_mac_tuser_err));
  assign end_ok     = wr_beat && i_mac_tlast && !i_mac_tuser_err;

  // First beat carries the live stamp, later beats the latched one
  assign ts_cur = first ? i_stamp_counter : ts_q;

  always_comb begin
    tuser = '0;
    tuser[SRC_PORT_HI:SRC_PORT_LO] = i_port_num;
    tuser[TS_HI:TS_LO]             = ts_cur;
  end

  always_ff @(posedge axis_aclk) begin
    if (i_reset) begin
      wr_ptr     <= '0;
      commit_ptr <= '0;
      rd_ptr     <= '0;
      beat_cnt   <= '0;
      in_frame   <= 1'b0;
      discard    <= 1'b0;
    end else begin
      if (rollback) begin
        wr_ptr <= commit_ptr;
      end else if (wr_beat) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (end_ok) begin
        commit_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (i_mac_tvalid) begin
        in_frame <= !i_mac_tlast;
        discard  <= !keep_frame || too_long;
        beat_cnt <= first ? PTR_W'(1) : beat_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge axis_aclk) begin
    if (i_mac_tvalid && first) begin
      ts_q <= i_stamp_counter;
    end
    if (wr_beat) begin
      mem[wr_ptr[PTR_W-1:0]] <= {i_mac_tlast, i_mac_tkeep, i_mac_tdata, tuser};
    end
  end

  // ----------------------------------------
  // Pipeline side, committed frames only
  // ----------------------------------------
  assign o_pipe.tvalid = (rd_ptr != commit_ptr);
  assign {o_pipe.tlast, o_pipe.tkeep, o_pipe.tdata, o_pipe.tuser} = mem[rd_ptr[PTR_W-1:0]];
  assign rd_en         = o_pipe.tvalid && o_pipe.tready;

  assign stat.rx_mac_eop  = i_mac_tvalid && i_mac_tlast;
  assign stat.rx_drop     = i_mac_tvalid && i_mac_tlast && !end_ok;
  assign stat.rx_pipe_eop = rd_en && o_pipe.tlast;

endmodule

/* rtl/stat_if.sv */
/*
  Packet event pulses from both queues, counter values and the counter clear.
  The queues drive events, the counters count them and the registers read them.
*/
`timescale 1ns/1ps

interface stat_if;
  import mac_attach_pkg::*;

  // One-cycle event pulses
  logic             rx_mac_eop;
  logic             rx_drop;
  logic             rx_pipe_eop;
  logic             tx_pipe_eop;
  logic             tx_mac_eop;

  // Counter values, top bit is the sticky overflow flag
  logic [CNT_W-1:0] rx_mac_pkts;
  logic [CNT_W-1:0] rx_drop_pkts;
  logic [CNT_W-1:0] rx_pipe_pkts;
  logic [CNT_W-1:0] tx_pipe_pkts;
  logic [CNT_W-1:0] tx_mac_pkts;
  logic             clear;

  modport rx_q (output rx_mac_eop, rx_drop, rx_pipe_eop);
  modport tx_q (output tx_pipe_eop, tx_mac_eop);

  modport cnt (
    input  rx_mac_eop, rx_drop, rx_pipe_eop, tx_pipe_eop, tx_mac_eop, clear,
    output rx_mac_pkts, rx_drop_pkts, rx_pipe_pkts, tx_pipe_pkts, tx_mac_pkts
  );

  modport regs (
    input  rx_mac_pkts, rx_drop_pkts, rx_pipe_pkts, tx_pipe_pkts, tx_mac_pkts,
    output clear
  );

endinterface

/* rtl/axis_if.sv */
/*
  AXI-Stream bundle used between blocks inside the attachment design
*/
`timescale 1ns/1ps

interface axis_if;
  import mac_attach_pkg::*;

  logic [DATA_W-1:0]  tdata;
  logic [KEEP_W-1:0]  tkeep;
  logic               tlast;
  logic [TUSER_W-1:0] tuser;
  logic               tvalid;
  logic               tready;

  modport src (
    output tdata, tkeep, tlast, tuser, tvalid,
    input  tready
  );

  modport snk (
    input  tdata, tkeep, tlast, tuser, tvalid,
    output tready
  );

endinterface

/* rtl/mac_attach_pkg.sv */
/*
  Shared widths, tuser field layout and register map for the MAC attachment block.
  Imported by every RTL file that needs a width or a register address.
*/
package mac_attach_pkg;

  // Stream geometry
  localparam int DATA_W  = 64;
  localparam int KEEP_W  = 8;
  localparam int TUSER_W = 128;
  localparam int TS_W    = 64;
  localparam int PORT_W  = 8;

  // Queue sizing
  localparam int FIFO_DEPTH      = 64;
  localparam int PTR_W           = 6;
  localparam int MAX_FRAME_BEATS = 16;

  // Statistics and register port
  localparam int CNT_W      = 32;
  localparam int REG_W      = 32;
  localparam int REG_ADDR_W = 8;

  localparam logic [REG_W-1:0] ID_VALUE      = 32'h0000_4D41;
  localparam logic [REG_W-1:0] VERSION_VALUE = 32'h0001_0000;
  localparam logic [REG_W-1:0] DEBUG_DEFAULT = 32'h0000_0000;

  // tuser layout, unlisted bits stay zero
  localparam int SRC_PORT_LO = 16;
  localparam int SRC_PORT_HI = 23;
  localparam int TS_LO       = 32;
  localparam int TS_HI       = 95;

  typedef enum logic [REG_ADDR_W-1:0] {
    ID           = 8'h00,
    VERSION      = 8'h04,
    RESET        = 8'h08,
    FLIP         = 8'h0C,
    DEBUG        = 8'h10,
    RX_MAC_PKTS  = 8'h14,
    RX_DROP_PKTS = 8'h18,
    RX_PIPE_PKTS = 8'h1C,
    TX_PIPE_PKTS = 8'h20,
    TX_MAC_PKTS  = 8'h24
  } reg_addr_e;

  typedef enum logic [1:0] {
    IDLE,
    ACK,
    RELEASE
  } reg_state_e;

endpackage
